/* common/softermax_pkg.sv */
// Shared widths, lane types, beat structs, reciprocal table and phase enum for the softermax unit
`default_nettype none

package softermax_pkg;

    localparam int LANES = 4;

    localparam int LOGIT_WIDTH = 8;
    localparam int LOGIT_FRAC = 4;
    localparam int VALUE_WIDTH = 16;
    localparam int VALUE_FRAC = 15;
    localparam int MAX_WIDTH = 5;
    localparam int OUT_WIDTH = 8;
    localparam int OUT_FRAC = 7;
    // 64 beats of four values below 2.0
    localparam int SUM_WIDTH = 24;
    localparam int RECIP_WIDTH = 32;
    localparam int RECIP_FRAC = 24;

    typedef logic signed [LOGIT_WIDTH-1:0] logit_t;
    typedef logic [VALUE_WIDTH-1:0] value_t;
    typedef logic [OUT_WIDTH-1:0] prob_t;

    typedef struct packed {
        logit_t [LANES-1:0] logit;
    } logit_beat_t;

    typedef struct packed {
        logic signed [MAX_WIDTH-1:0] local_max;
        value_t [LANES-1:0] value;
    } local_beat_t;

    typedef struct packed {
        prob_t [LANES-1:0] prob;
    } prob_beat_t;

    // Linear segments of 1/m over [1, 2), slope and intercept in Q2.14
    localparam int RECIP_ENTRIES = 8;
    localparam int RECIP_TABLE_WIDTH = 16;
    localparam int RECIP_TABLE_FRAC = 14;

    localparam logic [RECIP_TABLE_WIDTH-1:0] recip_slope [RECIP_ENTRIES] = '{
        16'd14564, 16'd11651, 16'd9533, 16'd7944,
        16'd6722, 16'd5761, 16'd4993, 16'd4369
    };

    localparam logic [RECIP_TABLE_WIDTH-1:0] recip_icept [RECIP_ENTRIES] = '{
        16'd30948, 16'd27671, 16'd25023, 16'd22838,
        16'd21005, 16'd19445, 16'd18100, 16'd16930
    };

    typedef enum logic [1:0] {
        GATHER,
        SUM,
        RECIP,
        SCALE
    } norm_phase_e;

endpackage

`default_nettype wire

/* hw/stream_fifo.sv */
// Synchronous valid/ready FIFO, circular buffer with occupancy count
`default_nettype none

module stream_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic [DATA_WIDTH-1:0] push_data,
    input  logic                  push_valid,
    output logic                  push_ready,

    output logic [DATA_WIDTH-1:0] pop_data,
    output logic                  pop_valid,
    input  logic                  pop_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    // A pop in the same cycle frees the slot of a full buffer
    assign push_ready = (count != CNT_W'(DEPTH)) || pop_ready;
    assign pop_valid = (count != '0);
    assign pop_data = mem[rd_ptr];

    assign do_push = push_valid && push_ready;
    assign do_pop = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

/* hw/softermax_local_window.sv */
// Local stage: per-beat integer maximum and base-2 exponential of each lane, one registered beat
`default_nettype none

module softermax_local_window (
    input  logic                       clk,
    input  logic                       reset,

    input  softermax_pkg::logit_beat_t in_beat,
    input  logic                       in_valid,
    output logic                       in_ready,

    output softermax_pkg::local_beat_t local_beat,
    output logic                       local_valid,
    input  logic                       local_ready
);

    import softermax_pkg::*;

    localparam int DIFF_WIDTH = LOGIT_WIDTH + 2;
    localparam int SHIFT_WIDTH = DIFF_WIDTH - LOGIT_FRAC;

    logic signed [MAX_WIDTH-1:0] ceil_int [LANES];
    logic signed [MAX_WIDTH-1:0] max_lo;
    logic signed [MAX_WIDTH-1:0] max_hi;
    logic signed [MAX_WIDTH-1:0] beat_max;
    logic signed [DIFF_WIDTH-1:0] diff [LANES];
    logic [SHIFT_WIDTH-1:0] exp_shift [LANES];
    local_beat_t next_beat;

    // Ceiling of the integer part by rounding up before the arithmetic shift
    always_comb begin
        logic signed [LOGIT_WIDTH:0] rounded;
        for (int i = 0; i < LANES; i++) begin
            rounded = $signed({in_beat.logit[i][LOGIT_WIDTH-1], in_beat.logit[i]})
                      + $signed((LOGIT_WIDTH + 1)'(2 ** LOGIT_FRAC - 1));
            ceil_int[i] = rounded[LOGIT_WIDTH:LOGIT_FRAC];
        end
    end

    // Two-level comparison tree
    assign max_lo = (ceil_int[0] > ceil_int[1]) ? ceil_int[0] : ceil_int[1];
    assign max_hi = (ceil_int[2] > ceil_int[3]) ? ceil_int[2] : ceil_int[3];
    assign beat_max = (max_lo > max_hi) ? max_lo : max_hi;

    always_comb begin
        next_beat.local_max = beat_max;
        for (int i = 0; i < LANES; i++) begin
            diff[i] = $signed({{2{in_beat.logit[i][LOGIT_WIDTH-1]}}, in_beat.logit[i]})
                      - $signed({beat_max[MAX_WIDTH-1], beat_max, LOGIT_FRAC'(0)});
            // d <= 0, so the shift is minus the integer floor
            exp_shift[i] = SHIFT_WIDTH'(0) - diff[i][DIFF_WIDTH-1:LOGIT_FRAC];
            next_beat.value[i] = (value_t'({1'b1, diff[i][LOGIT_FRAC-1:0]})
                                  << (VALUE_FRAC - LOGIT_FRAC)) >> exp_shift[i];
        end
    end

    assign in_ready = !local_valid || local_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            local_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            local_valid <= 1'b1;
        end else if (local_ready) begin
            local_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            local_beat <= next_beat;
        end
    end

endmodule

`default_nettype wire

/* global_norm/softermax_lpw_reciprocal.sv */
// Piecewise-linear reciprocal of the vector sum, normalized by leading one and table lookup
`default_nettype none

module softermax_lpw_reciprocal (
    input  logic                                 clk,
    input  logic                                 reset,

    input  logic [softermax_pkg::SUM_WIDTH-1:0]   sum,
    input  logic                                 sum_valid,
    output logic                                 sum_ready,

    output logic [softermax_pkg::RECIP_WIDTH-1:0] recip,
    output logic                                 recip_valid,
    input  logic                                 recip_ready
);

    import softermax_pkg::*;

    localparam int LEAD_W = $clog2(SUM_WIDTH);
    localparam int IDX_W = $clog2(RECIP_ENTRIES);
    // Gap between table and output fraction bits
    localparam int UP = RECIP_FRAC - RECIP_TABLE_FRAC;
    localparam int WIDE_W = RECIP_WIDTH + UP;

    typedef enum logic [1:0] {
        RCP_IDLE,
        RCP_CALC,
        RCP_DONE
    } recip_state_e;

    recip_state_e state;
    logic [LEAD_W-1:0] lead;
    logic [SUM_WIDTH-1:0] norm;
    logic [VALUE_WIDTH-1:0] mant_reg;
    logic [LEAD_W-1:0] lead_reg;
    logic zero_reg;
    logic [IDX_W-1:0] idx;
    logic [RECIP_WIDTH-1:0] r_reg;
    logic [WIDE_W-1:0] wide;

    // Highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < SUM_WIDTH; i++) begin
            if (sum[i]) lead = LEAD_W'(i);
        end
    end

    assign norm = sum << (LEAD_W'(SUM_WIDTH - 1) - lead);
    assign idx = mant_reg[VALUE_FRAC-1 -: IDX_W];

    assign sum_ready = (state == RCP_IDLE);
    assign recip_valid = (state == RCP_DONE);

    // Undo the normalization shift, saturating on overflow
    assign wide = {r_reg, UP'(0)} >> lead_reg;
    assign recip = (zero_reg || |wide[WIDE_W-1:RECIP_WIDTH]) ? '1 : wide[RECIP_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RCP_IDLE;
        end else begin
            case (state)
                RCP_IDLE: if (sum_valid) state <= RCP_CALC;
                RCP_CALC: state <= RCP_DONE;
                RCP_DONE: if (recip_ready) state <= RCP_IDLE;
                default: state <= RCP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RCP_IDLE && sum_valid) begin
            mant_reg <= norm[SUM_WIDTH-1 -: VALUE_WIDTH];
            lead_reg <= lead;
            zero_reg <= (sum == '0);
        end
        if (state == RCP_CALC) begin
            r_reg <= {1'b0, recip_icept[idx], VALUE_FRAC'(0)}
                   - RECIP_WIDTH'(recip_slope[idx]) * RECIP_WIDTH'(mant_reg);
        end
    end

endmodule

`default_nettype wire

/* global_norm/softermax_global_norm.sv */
// Global stage: gathers one vector, renormalizes to the global max, sums, and scales by 1/sum
`default_nettype none

module softermax_global_norm #(
    parameter int TOTAL_DIM = 16
) (
    input  logic                       clk,
    input  logic                       reset,

    input  softermax_pkg::local_beat_t local_beat,
    input  logic                       local_valid,
    output logic                       local_ready,

    output softermax_pkg::prob_beat_t  out_beat,
    output logic                       out_valid,
    input  logic                       out_ready
);

    import softermax_pkg::*;

    localparam int DEPTH = TOTAL_DIM / LANES;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int PROD_WIDTH = VALUE_WIDTH + RECIP_WIDTH;
    // Product fraction bits dropped by the floor
    localparam int DROP = VALUE_FRAC + RECIP_FRAC - OUT_FRAC;

    norm_phase_e phase;
    logic [CNT_W-1:0] beat_cnt;
    logic last_beat;
    logic signed [MAX_WIDTH-1:0] global_max;
    logic [SUM_WIDTH-1:0] sum_acc;
    logic [SUM_WIDTH-1:0] lane_sum;
    logic [MAX_WIDTH:0] shift_amt;
    logic [RECIP_WIDTH-1:0] recip_reg;
    logic [PROD_WIDTH-1:0] prod [LANES];

    local_beat_t push_beat;
    local_beat_t pop_beat;
    local_beat_t renorm_beat;
    logic push_valid;
    logic push_ready;
    logic pop_valid;
    logic pop_ready;

    logic sum_valid;
    logic sum_ready;
    logic sum_sent;
    logic [RECIP_WIDTH-1:0] recip;
    logic recip_valid;
    logic recip_ready;

    assign last_beat = (beat_cnt == CNT_W'(DEPTH - 1));

    // FIFO routing per phase
    assign local_ready = (phase == GATHER) && push_ready;
    assign push_valid = ((phase == GATHER) && local_valid) || ((phase == SUM) && pop_valid);
    assign push_beat = (phase == SUM) ? renorm_beat : local_beat;
    assign pop_ready = (phase == SUM) || ((phase == SCALE) && out_ready);

    assign sum_valid = (phase == RECIP) && !sum_sent;
    assign recip_ready = (phase == RECIP);
    assign out_valid = (phase == SCALE) && pop_valid;

    assign shift_amt = {global_max[MAX_WIDTH-1], global_max}
                     - {pop_beat.local_max[MAX_WIDTH-1], pop_beat.local_max};

    always_comb begin
        renorm_beat.local_max = global_max;
        lane_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            // Shifts of 16 or more clear the value
            renorm_beat.value[i] = pop_beat.value[i] >> shift_amt;
            lane_sum = lane_sum + SUM_WIDTH'(renorm_beat.value[i]);
            prod[i] = PROD_WIDTH'(pop_beat.value[i]) * PROD_WIDTH'(recip_reg);
            out_beat.prob[i] = (|prod[i][PROD_WIDTH-1:DROP+OUT_WIDTH]) ? '1
                             : prod[i][DROP+OUT_WIDTH-1:DROP];
        end
    end

    stream_fifo #(
        .DATA_WIDTH($bits(local_beat_t)),
        .DEPTH     (DEPTH)
    ) i_beat_fifo (
        .clk       (clk),
        .reset     (reset),
        .push_data (push_beat),
        .push_valid(push_valid),
        .push_ready(push_ready),
        .pop_data  (pop_beat),
        .pop_valid (pop_valid),
        .pop_ready (pop_ready)
    );

    softermax_lpw_reciprocal i_reciprocal (
        .clk        (clk),
        .reset      (reset),
        .sum        (sum_acc),
        .sum_valid  (sum_valid),
        .sum_ready  (sum_ready),
        .recip      (recip),
        .recip_valid(recip_valid),
        .recip_ready(recip_ready)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= GATHER;
            beat_cnt <= '0;
            sum_sent <= 1'b0;
        end else begin
            case (phase)
                GATHER: if (local_valid && local_ready) begin
                    beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
                    if (last_beat) phase <= SUM;
                end
                SUM: if (pop_valid) begin
                    beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
                    if (last_beat) phase <= RECIP;
                end
                RECIP: begin
                    if (sum_valid && sum_ready) sum_sent <= 1'b1;
                    if (recip_valid) begin
                        sum_sent <= 1'b0;
                        phase <= SCALE;
                    end
                end
                SCALE: if (out_valid && out_ready) begin
                    beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
                    if (last_beat) phase <= GATHER;
                end
                default: phase <= GATHER;
            endcase
        end
    end

    // Max, sum and reciprocal restart with every vector
    always_ff @(posedge clk) begin
        if (phase == GATHER && local_valid && local_ready) begin
            if (beat_cnt == '0 || local_beat.local_max > global_max) begin
                global_max <= local_beat.local_max;
            end
            if (last_beat) sum_acc <= '0;
        end
        if (phase == SUM && pop_valid) sum_acc <= sum_acc + lane_sum;
        if (recip_valid && recip_ready) recip_reg <= recip;
    end

endmodule

`default_nettype wire

/* hw/softermax_top.sv */
// Softermax top level, local max/exp stage feeding the vector-wide normalization stage
`default_nettype none

module softermax_top #(
    parameter int TOTAL_DIM = 16
) (
    input  logic                      clk,
    input  logic                      reset,

    input  softermax_pkg::logit_beat_t in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,

    output softermax_pkg::prob_beat_t  out_beat,
    output logic                      out_valid,
    input  logic                      out_ready
);

    import softermax_pkg::*;

    local_beat_t local_beat;
    logic local_valid;
    logic local_ready;

    softermax_local_window i_local_window (
        .clk        (clk),
        .reset      (reset),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .local_beat (local_beat),
        .local_valid(local_valid),
        .local_ready(local_ready)
    );

    softermax_global_norm #(
        .TOTAL_DIM(TOTAL_DIM)
    ) i_global_norm (
        .clk        (clk),
        .reset      (reset),
        .local_beat (local_beat),
        .local_valid(local_valid),
        .local_ready(local_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

/* dv/softermax_props.sv */
// Handshake assertions for the softermax top level, attached to every softermax_top by bind
`default_nettype none

module softermax_props (
    input logic                      clk,
    input logic                      reset,
    input logic                      in_valid,
    input logic                      in_ready,
    input softermax_pkg::prob_beat_t out_beat,
    input logic                      out_valid,
    input logic                      out_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Back-pressure holds the output beat
    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else begin
        fail_count++;
        $error("out_beat or out_valid changed while out_ready was low");
    end

    out_idle_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
        fail_count++;
        $error("out_valid was high in the cycle after reset");
    end

    in_hold: assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid)
    else begin
        fail_count++;
        $error("in_valid dropped before its beat was accepted");
    end

endmodule

bind softermax_top softermax_props i_softermax_props (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_beat (out_beat),
    .out_valid(out_valid),
    .out_ready(out_ready)
);

`default_nettype wire

/* dv/softermax_tb.sv */
// Top-level testbench that drives random softermax vectors and checks each output beat against a model
`default_nettype none

module softermax_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import softermax_pkg::*;

    localparam int TOTAL_DIM = 16;
    localparam int DEPTH = TOTAL_DIM / LANES;
    localparam int TIMEOUT_CYCLES = 1000;
    localparam int KIND_RANDOM = 0;
    localparam int KIND_EQUAL = 1;
    localparam int KIND_DOMINANT = 2;

    logic clk;
    logic reset;
    logit_beat_t in_beat;
    logic in_valid;
    logic in_ready;
    prob_beat_t out_beat;
    logic out_valid;
    logic out_ready;

    int mismatch_count = 0;
    int timeout_count = 0;
    logic [31:0] rng_state = 32'd20964;
    int vec [TOTAL_DIM];
    logit_beat_t stim_q[$];
    int gap_q[$];
    prob_beat_t expect_q[$];
    prob_beat_t got_q[$];

    softermax_top #(
        .TOTAL_DIM(TOTAL_DIM)
    ) i_softermax_top (
        .clk      (clk),
        .reset    (reset),
        .in_beat  (in_beat),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_beat (out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Integer ceiling of a Q4.4 logit
    function automatic int ceil_int(input int logit);
        return (logit + 15) >>> LOGIT_FRAC;
    endfunction

    // 2^d as (1 + frac(d)) >> -floor(d) in Q1.15
    function automatic int lane_exp(input int logit, input int local_max);
        int d;
        int shift;
        d = logit - local_max * 16;
        shift = -(d >>> LOGIT_FRAC);
        if (shift >= 16) begin
            return 0;
        end
        return ((16 + (d & 15)) << (VALUE_FRAC - LOGIT_FRAC)) >> shift;
    endfunction

    // Table segment over the mantissa in [1, 2) scaled back into Q8.24
    function automatic longint recip_model(input longint sum);
        int lead;
        int k;
        longint mant;
        longint r;
        longint w;
        if (sum == 0) begin
            return 64'hFFFF_FFFF;
        end
        lead = 0;
        for (int i = 0; i < SUM_WIDTH; i++) begin
            if (sum[i]) begin
                lead = i;
            end
        end
        mant = (sum << (SUM_WIDTH - 1 - lead)) >> (SUM_WIDTH - VALUE_WIDTH);
        k = int'((mant >> (VALUE_FRAC - 3)) & 7);
        // Q2.14 slope times Q1.15 mantissa lands on 29 fraction bits
        r = (longint'(recip_icept[k]) << VALUE_FRAC) - longint'(recip_slope[k]) * mant;
        r = r & 64'hFFFF_FFFF;
        w = (r << (RECIP_FRAC - RECIP_TABLE_FRAC)) >> lead;
        return (w > 64'hFFFF_FFFF) ? 64'hFFFF_FFFF : w;
    endfunction

    // Equal logits share one exponential v and one reciprocal of TOTAL_DIM times v
    function automatic int equal_prob(input int level);
        int v;
        longint prod;
        v = lane_exp(level, ceil_int(level));
        prod = (longint'(v) * recip_model(longint'(TOTAL_DIM * v)))
               >> (VALUE_FRAC + RECIP_FRAC - OUT_FRAC);
        return (prod > 255) ? 255 : int'(prod);
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            mismatch_count++;
            $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic print_counts();
        $display("mismatches %0d, timeouts %0d, assertion failures %0d", mismatch_count,
                 timeout_count, i_softermax_top.i_softermax_props.fail_count);
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout: %s", what);
        print_counts();
        $display("sim failed");
        $finish;
    endtask

    task automatic make_vector(input int kind, output int pos);
        int level;
        pos = int'(next_rand() % TOTAL_DIM);
        level = logit_t'(next_rand());
        for (int i = 0; i < TOTAL_DIM; i++) begin
            case (kind)
                KIND_RANDOM: vec[i] = logit_t'(next_rand());
                KIND_EQUAL: vec[i] = level;
                // Widest spread of the format gives 16 shifts after rounding
                default: vec[i] = (i == pos) ? 127 : -128;
            endcase
        end
    endtask

    // Queues the beats of vec and the expected probabilities
    task automatic add_vector(input int gap_max);
        int local_max [DEPTH];
        int renorm [TOTAL_DIM];
        int global_max;
        int shift;
        longint sum;
        longint recip;
        longint prod;
        logit_beat_t beat;
        prob_beat_t exp_beat;
        global_max = -1000;
        for (int b = 0; b < DEPTH; b++) begin
            local_max[b] = -1000;
            for (int l = 0; l < LANES; l++) begin
                beat.logit[l] = logit_t'(vec[b * LANES + l]);
                if (ceil_int(vec[b * LANES + l]) > local_max[b]) begin
                    local_max[b] = ceil_int(vec[b * LANES + l]);
                end
            end
            if (local_max[b] > global_max) begin
                global_max = local_max[b];
            end
            stim_q.push_back(beat);
            gap_q.push_back((gap_max > 0) ? int'(next_rand() % (gap_max + 1)) : 0);
        end
        sum = 0;
        for (int i = 0; i < TOTAL_DIM; i++) begin
            shift = global_max - local_max[i / LANES];
            renorm[i] = lane_exp(vec[i], local_max[i / LANES]);
            renorm[i] = (shift >= 16) ? 0 : renorm[i] >> shift;
            sum += renorm[i];
        end
        recip = recip_model(sum);
        for (int b = 0; b < DEPTH; b++) begin
            for (int l = 0; l < LANES; l++) begin
                prod = (longint'(renorm[b * LANES + l]) * recip)
                       >> (VALUE_FRAC + RECIP_FRAC - OUT_FRAC);
                exp_beat.prob[l] = (prod > 255) ? 8'd255 : prob_t'(prod);
            end
            expect_q.push_back(exp_beat);
        end
    endtask

    task automatic drive_beats();
        int waited;
        int gap;
        @(posedge clk);
        #1;
        while (stim_q.size() > 0) begin
            in_beat = stim_q.pop_front();
            gap = gap_q.pop_front();
            in_valid = 1'b1;
            waited = 0;
            @(negedge clk);
            while (!in_ready) begin
                waited++;
                if (waited >= TIMEOUT_CYCLES) report_timeout("input beat was never accepted");
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            if (gap > 0) begin
                in_valid = 1'b0;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_beats(input string name, input bit random_ready);
        int waited;
        int count;
        prob_beat_t exp_beat;
        count = expect_q.size();
        for (int b = 0; b < count; b++) begin
            waited = 0;
            do begin
                @(posedge clk);
                #1;
                out_ready = random_ready ? (next_rand() % 4 != 0) : 1'b1;
                @(negedge clk);
                waited++;
                if (waited >= TIMEOUT_CYCLES) report_timeout("output beat never arrived");
            end while (!(out_valid && out_ready));
            exp_beat = expect_q.pop_front();
            got_q.push_back(out_beat);
            for (int l = 0; l < LANES; l++) begin
                check_value($sformatf("%s beat %0d lane %0d", name, b, l),
                            exp_beat.prob[l], out_beat.prob[l]);
            end
        end
    endtask

    task automatic run_traffic(input string name, input bit random_ready);
        got_q.delete();
        fork
            drive_beats();
            collect_beats(name, random_ready);
        join
        @(posedge clk);
        #1;
        out_ready = 1'b1;
        // No beat beyond the expected ones
        repeat (2 * TOTAL_DIM) begin
            @(negedge clk);
            check_value({name, " extra beat"}, 0, out_valid);
        end
    endtask

    initial begin
        int pos;
        int dom_pos [2];
        int equal_exp [2];
        in_beat = '0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        repeat (4) begin
            make_vector(KIND_RANDOM, pos);
            add_vector(0);
        end
        run_traffic("random_vectors", 1'b0);

        repeat (4) begin
            make_vector(KIND_RANDOM, pos);
            add_vector(3);
        end
        run_traffic("random_flow", 1'b1);

        for (int v = 0; v < 2; v++) begin
            make_vector(KIND_EQUAL, pos);
            equal_exp[v] = equal_prob(vec[0]);
            add_vector(1);
        end
        run_traffic("equal_logits", 1'b1);
        for (int v = 0; v < 2; v++) begin
            for (int i = 0; i < TOTAL_DIM; i++) begin
                check_value("equal_logits spread", equal_exp[v],
                            got_q[v * DEPTH + i / LANES].prob[i % LANES]);
            end
        end

        for (int v = 0; v < 2; v++) begin
            make_vector(KIND_DOMINANT, dom_pos[v]);
            add_vector(0);
        end
        run_traffic("dominant_logit", 1'b0);
        for (int v = 0; v < 2; v++) begin
            for (int i = 0; i < TOTAL_DIM; i++) begin
                if (i != dom_pos[v]) begin
                    check_value("dominant_logit rest", 0,
                                got_q[v * DEPTH + i / LANES].prob[i % LANES]);
                end
            end
        end

        for (int v = 0; v < 6; v++) begin
            make_vector(v % 3, pos);
            add_vector(0);
        end
        run_traffic("back_to_back", 1'b0);

        print_counts();
        if (mismatch_count == 0 && timeout_count == 0
            && i_softermax_top.i_softermax_props.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
common/softermax_pkg.sv
hw/stream_fifo.sv
hw/softermax_local_window.sv
global_norm/softermax_lpw_reciprocal.sv
global_norm/softermax_global_norm.sv
hw/softermax_top.sv
dv/softermax_props.sv
dv/softermax_tb.sv
